/* src/cpuPkg.sv */
`default_nettype none

package cpuPkg;

	// --------------------------------------------------
	// Sizes
	// --------------------------------------------------
	localparam int xlen = 32;
	localparam int regAddrW = 5;
	// Program counter counts words, not bytes
	localparam int pcW = 6;
	localparam int imemDepth = 64;
	localparam int dmemDepth = 64;
	localparam int dmemAddrW = 6;

	// --------------------------------------------------
	// Encodings
	// --------------------------------------------------
	typedef enum logic [5:0] {
		opRtype = 6'd0,
		opBeq = 6'd4,
		opAddi = 6'd8,
		opLw = 6'd35,
		opSw = 6'd43
	} opcodeE;

	typedef enum logic [5:0] {
		fnAdd = 6'd32,
		fnSub = 6'd34,
		fnAnd = 6'd36,
		fnOr = 6'd37,
		fnSlt = 6'd42
	} functE;

	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluSlt
	} aluOpE;

	// Operand source in execute
	typedef enum logic [1:0] {
		fwdReg,
		fwdMem,
		fwdWb
	} fwdSelE;

	// --------------------------------------------------
	// Stage registers
	// --------------------------------------------------
	typedef struct packed {
		logic valid;
		logic [xlen-1:0] instr;
		logic [pcW-1:0] pcPlus1;
	} ifIdT;

	typedef struct packed {
		logic valid;
		logic regWrite;
		logic memToReg;
		logic memWrite;
		logic aluSrcImm;
		aluOpE aluOp;
		logic [regAddrW-1:0] rs;
		logic [regAddrW-1:0] rt;
		logic [regAddrW-1:0] dest;
		logic [xlen-1:0] rd1;
		logic [xlen-1:0] rd2;
		logic [xlen-1:0] imm;
	} idExT;

	typedef struct packed {
		logic valid;
		logic regWrite;
		logic memToReg;
		logic memWrite;
		logic [xlen-1:0] aluOut;
		logic [xlen-1:0] writeData;
		logic [regAddrW-1:0] dest;
	} exMemT;

	typedef struct packed {
		logic valid;
		logic regWrite;
		logic memToReg;
		logic [xlen-1:0] readData;
		logic [xlen-1:0] aluOut;
		logic [regAddrW-1:0] dest;
	} memWbT;

	// Writeback bus, en already excludes register 0
	typedef struct packed {
		logic en;
		logic [regAddrW-1:0] dest;
		logic [xlen-1:0] result;
	} wbT;

endpackage

`default_nettype wire

/* src/fetchStage.sv */
`timescale 1ns/1ps
`default_nettype none

module fetchStage (
	input wire clk,
	input wire rstN,
	input wire run,
	input wire stall,
	input wire branchTaken,
	input wire [cpuPkg::pcW-1:0] branchTarget,
	input wire progWe,
	input wire [cpuPkg::pcW-1:0] progAddr,
	input wire [cpuPkg::xlen-1:0] progData,
	output cpuPkg::ifIdT ifId
);

	logic [cpuPkg::xlen-1:0] imem [cpuPkg::imemDepth];
	logic [cpuPkg::pcW-1:0] pc;
	logic [cpuPkg::pcW-1:0] pcPlus1;

	assign pcPlus1 = pc + 1'b1;

	// Load port, only open while halted
	always_ff @(posedge clk)
	begin
		if (progWe && !run)
			imem[progAddr] <= progData;
	end

	// --------------------------------------------------
	// PC and fetch/decode register
	// --------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			pc <= '0;
			ifId.valid <= 1'b0;
		end
		else if (!run)
		begin
			// Parked at 0 until run rises
			pc <= '0;
			ifId.valid <= 1'b0;
		end
		else if (!stall)
		begin
			if (branchTaken)
			begin
				// Redirect, kill the wrong-path fetch
				pc <= branchTarget;
				ifId.valid <= 1'b0;
			end
			else
			begin
				pc <= pcPlus1;
				ifId.valid <= 1'b1;
				ifId.instr <= imem[pc];
				ifId.pcPlus1 <= pcPlus1;
			end
		end
	end

endmodule

`default_nettype wire

/* src/decodeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
	input wire clk,
	input wire rstN,
	input wire cpuPkg::ifIdT ifId,
	input wire cpuPkg::wbT wb,
	input wire [cpuPkg::xlen-1:0] exMemAlu,
	input wire brFwdA,
	input wire brFwdB,
	input wire flushEx,
	output logic [cpuPkg::regAddrW-1:0] rs,
	output logic [cpuPkg::regAddrW-1:0] rt,
	output logic isBranch,
	output logic usesRt,
	output logic branchTaken,
	output logic [cpuPkg::pcW-1:0] branchTarget,
	output cpuPkg::idExT idEx
);

	logic [cpuPkg::xlen-1:0] regs [2**cpuPkg::regAddrW];
	cpuPkg::opcodeE opcode;
	cpuPkg::functE funct;
	logic [cpuPkg::regAddrW-1:0] instrRs;
	logic [cpuPkg::regAddrW-1:0] instrRt;
	logic [cpuPkg::regAddrW-1:0] instrRd;
	logic [cpuPkg::xlen-1:0] imm;
	logic [cpuPkg::xlen-1:0] rd1;
	logic [cpuPkg::xlen-1:0] rd2;
	logic [cpuPkg::xlen-1:0] brA;
	logic [cpuPkg::xlen-1:0] brB;
	logic regWrite;
	logic memToReg;
	logic memWrite;
	logic aluSrcImm;
	logic useRd;
	logic rtSrc;
	logic branch;
	cpuPkg::aluOpE aluOp;

	// Field split
	assign opcode = cpuPkg::opcodeE'(ifId.instr[31:26]);
	assign funct = cpuPkg::functE'(ifId.instr[5:0]);
	assign instrRs = ifId.instr[25:21];
	assign instrRt = ifId.instr[20:16];
	assign instrRd = ifId.instr[15:11];
	assign imm = {{(cpuPkg::xlen-16){ifId.instr[15]}}, ifId.instr[15:0]};

	// --------------------------------------------------
	// Control decode
	// --------------------------------------------------
	always_comb
	begin
		regWrite = 1'b0;
		memToReg = 1'b0;
		memWrite = 1'b0;
		aluSrcImm = 1'b0;
		useRd = 1'b0;
		rtSrc = 1'b0;
		branch = 1'b0;
		aluOp = cpuPkg::aluAdd;
		case (opcode)
			cpuPkg::opRtype:
			begin
				useRd = 1'b1;
				rtSrc = 1'b1;
				regWrite = 1'b1;
				case (funct)
					cpuPkg::fnAdd: aluOp = cpuPkg::aluAdd;
					cpuPkg::fnSub: aluOp = cpuPkg::aluSub;
					cpuPkg::fnAnd: aluOp = cpuPkg::aluAnd;
					cpuPkg::fnOr: aluOp = cpuPkg::aluOr;
					cpuPkg::fnSlt: aluOp = cpuPkg::aluSlt;
					// Unknown funct, becomes a no-op
					default: regWrite = 1'b0;
				endcase
			end
			cpuPkg::opAddi:
			begin
				regWrite = 1'b1;
				aluSrcImm = 1'b1;
			end
			cpuPkg::opLw:
			begin
				regWrite = 1'b1;
				memToReg = 1'b1;
				aluSrcImm = 1'b1;
			end
			cpuPkg::opSw:
			begin
				memWrite = 1'b1;
				aluSrcImm = 1'b1;
				rtSrc = 1'b1;
			end
			cpuPkg::opBeq:
			begin
				branch = 1'b1;
				rtSrc = 1'b1;
			end
			default:
			begin
				// No writes of any kind
				regWrite = 1'b0;
			end
		endcase
	end

	// Hazard view, zero source when the slot is empty
	assign rs = ifId.valid ? instrRs : '0;
	assign rt = instrRt;
	assign isBranch = ifId.valid && branch;
	assign usesRt = ifId.valid && rtSrc;

	// --------------------------------------------------
	// Register file
	// --------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (wb.en)
			regs[wb.dest] <= wb.result;
	end

	// Write-through from the same-cycle writeback, r0 reads zero
	function automatic logic [cpuPkg::xlen-1:0] readPort(
		input logic [cpuPkg::regAddrW-1:0] addr
	);
		if (addr == '0)
			return '0;
		if (wb.en && wb.dest == addr)
			return wb.result;
		return regs[addr];
	endfunction

	always_comb
	begin
		rd1 = readPort(instrRs);
		rd2 = readPort(instrRt);
	end

	// Branch compare with memory-stage forwarding
	assign brA = brFwdA ? exMemAlu : rd1;
	assign brB = brFwdB ? exMemAlu : rd2;
	assign branchTaken = isBranch && (brA == brB);
	assign branchTarget = ifId.pcPlus1 + imm[cpuPkg::pcW-1:0];

	// --------------------------------------------------
	// Decode/execute register
	// --------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			idEx.valid <= 1'b0;
			idEx.regWrite <= 1'b0;
			idEx.memToReg <= 1'b0;
			idEx.memWrite <= 1'b0;
		end
		else if (flushEx || !ifId.valid)
		begin
			// Bubble
			idEx.valid <= 1'b0;
			idEx.regWrite <= 1'b0;
			idEx.memToReg <= 1'b0;
			idEx.memWrite <= 1'b0;
		end
		else
		begin
			idEx <= '{
				valid: 1'b1,
				regWrite: regWrite,
				memToReg: memToReg,
				memWrite: memWrite,
				aluSrcImm: aluSrcImm,
				aluOp: aluOp,
				rs: instrRs,
				rt: instrRt,
				dest: useRd ? instrRd : instrRt,
				rd1: rd1,
				rd2: rd2,
				imm: imm
			};
		end
	end

endmodule

`default_nettype wire

/* src/executeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module executeStage (
	input wire clk,
	input wire rstN,
	input wire cpuPkg::idExT idEx,
	input wire cpuPkg::fwdSelE fwdA,
	input wire cpuPkg::fwdSelE fwdB,
	input wire [cpuPkg::xlen-1:0] memAluOut,
	input wire cpuPkg::wbT wb,
	output cpuPkg::exMemT exMem
);

	logic [cpuPkg::xlen-1:0] srcA;
	logic [cpuPkg::xlen-1:0] storeData;
	logic [cpuPkg::xlen-1:0] srcB;
	logic [cpuPkg::xlen-1:0] aluOut;

	// Operand pick; fwdWb still checks the bus since the
	// writeback register sits outside the hazard unit's view
	function automatic logic [cpuPkg::xlen-1:0] pickSrc(
		input cpuPkg::fwdSelE sel,
		input logic [cpuPkg::regAddrW-1:0] idx,
		input logic [cpuPkg::xlen-1:0] regVal
	);
		case (sel)
			cpuPkg::fwdMem: return memAluOut;
			cpuPkg::fwdWb: return (wb.en && wb.dest == idx) ? wb.result : regVal;
			default: return regVal;
		endcase
	endfunction

	always_comb
	begin
		srcA = pickSrc(fwdA, idEx.rs, idEx.rd1);
		storeData = pickSrc(fwdB, idEx.rt, idEx.rd2);
	end

	assign srcB = idEx.aluSrcImm ? idEx.imm : storeData;

	// --------------------------------------------------
	// ALU
	// --------------------------------------------------
	always_comb
	begin
		case (idEx.aluOp)
			cpuPkg::aluAdd: aluOut = srcA + srcB;
			cpuPkg::aluSub: aluOut = srcA - srcB;
			cpuPkg::aluAnd: aluOut = srcA & srcB;
			cpuPkg::aluOr: aluOut = srcA | srcB;
			// Signed compare
			cpuPkg::aluSlt: aluOut = {{(cpuPkg::xlen-1){1'b0}}, $signed(srcA) < $signed(srcB)};
			default: aluOut = srcA + srcB;
		endcase
	end

	// Execute/memory register
	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			exMem.valid <= 1'b0;
			exMem.regWrite <= 1'b0;
			exMem.memToReg <= 1'b0;
			exMem.memWrite <= 1'b0;
		end
		else
		begin
			exMem <= '{
				valid: idEx.valid,
				regWrite: idEx.regWrite,
				memToReg: idEx.memToReg,
				memWrite: idEx.memWrite,
				aluOut: aluOut,
				writeData: storeData,
				dest: idEx.dest
			};
		end
	end

endmodule

`default_nettype wire

/* src/memoryStage.sv */
`timescale 1ns/1ps
`default_nettype none

module memoryStage (
	input wire clk,
	input wire rstN,
	input wire cpuPkg::exMemT exMem,
	output cpuPkg::wbT wb
);

	logic [cpuPkg::xlen-1:0] dmem [cpuPkg::dmemDepth];
	logic [cpuPkg::dmemAddrW-1:0] addr;
	cpuPkg::memWbT memWb;

	// aluOut holds a word address
	assign addr = exMem.aluOut[cpuPkg::dmemAddrW-1:0];

	// Store at the edge
	always_ff @(posedge clk)
	begin
		if (exMem.valid && exMem.memWrite)
			dmem[addr] <= exMem.writeData;
	end

	// --------------------------------------------------
	// Memory/writeback register
	// --------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			memWb.valid <= 1'b0;
			memWb.regWrite <= 1'b0;
			memWb.memToReg <= 1'b0;
		end
		else
		begin
			memWb.valid <= exMem.valid;
			memWb.regWrite <= exMem.regWrite;
			memWb.memToReg <= exMem.memToReg;
			// Combinational read
			memWb.readData <= dmem[addr];
			memWb.aluOut <= exMem.aluOut;
			memWb.dest <= exMem.dest;
		end
	end

	// Writeback bus, r0 never strobes
	always_comb
	begin
		wb.en = memWb.valid && memWb.regWrite && (memWb.dest != '0);
		wb.dest = memWb.dest;
		wb.result = memWb.memToReg ? memWb.readData : memWb.aluOut;
	end

endmodule

`default_nettype wire

/* src/hazardUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
	input wire [cpuPkg::regAddrW-1:0] rs,
	input wire [cpuPkg::regAddrW-1:0] rt,
	input wire isBranch,
	input wire usesRt,
	input wire cpuPkg::idExT idEx,
	input wire cpuPkg::exMemT exMem,
	output logic stall,
	output logic flushEx,
	output cpuPkg::fwdSelE fwdA,
	output cpuPkg::fwdSelE fwdB,
	output logic brFwdA,
	output logic brFwdB
);

	logic exWrites;
	logic exLoad;
	logic memWrites;
	logic memLoad;
	logic loadUse;
	logic brHazEx;
	logic brHazMem;

	// Live writers per stage, dest of 0 never counts
	assign exWrites = idEx.valid && idEx.regWrite && (idEx.dest != '0);
	assign exLoad = exWrites && idEx.memToReg;
	assign memWrites = exMem.valid && exMem.regWrite && (exMem.dest != '0);
	assign memLoad = memWrites && exMem.memToReg;

	// Memory stage first, else let execute match writeback
	function automatic cpuPkg::fwdSelE fwdFor(input logic [cpuPkg::regAddrW-1:0] src);
		if (src == '0)
			return cpuPkg::fwdReg;
		if (memWrites && exMem.dest == src)
			return cpuPkg::fwdMem;
		return cpuPkg::fwdWb;
	endfunction

	always_comb
	begin
		fwdA = fwdFor(idEx.rs);
		fwdB = fwdFor(idEx.rt);
	end

	// Branch operands from the memory-stage ALU result
	assign brFwdA = memWrites && !exMem.memToReg && (exMem.dest == rs);
	assign brFwdB = memWrites && !exMem.memToReg && (exMem.dest == rt);

	// --------------------------------------------------
	// Stalls
	// --------------------------------------------------
	assign loadUse = exLoad && ((idEx.dest == rs) || (usesRt && idEx.dest == rt));
	assign brHazEx = isBranch && exWrites && ((idEx.dest == rs) || (idEx.dest == rt));
	assign brHazMem = isBranch && memLoad && ((exMem.dest == rs) || (exMem.dest == rt));

	assign stall = loadUse || brHazEx || brHazMem;
	assign flushEx = stall;

endmodule

`default_nettype wire

/* src/cpuTop.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuTop (
	input wire clk,
	input wire rstN,
	input wire run,
	input wire progWe,
	input wire [cpuPkg::pcW-1:0] progAddr,
	input wire [cpuPkg::xlen-1:0] progData,
	output logic wbValid,
	output logic [cpuPkg::regAddrW-1:0] wbDest,
	output logic [cpuPkg::xlen-1:0] wbData
);

	// --------------------------------------------------
	// Stage registers and hazard wiring
	// --------------------------------------------------
	cpuPkg::ifIdT ifId;
	cpuPkg::idExT idEx;
	cpuPkg::exMemT exMem;
	cpuPkg::wbT wb;
	logic [cpuPkg::regAddrW-1:0] rs;
	logic [cpuPkg::regAddrW-1:0] rt;
	logic isBranch;
	logic usesRt;
	logic branchTaken;
	logic [cpuPkg::pcW-1:0] branchTarget;
	logic stall;
	logic flushEx;
	cpuPkg::fwdSelE fwdA;
	cpuPkg::fwdSelE fwdB;
	logic brFwdA;
	logic brFwdB;

	fetchStage fetch0 (
		.clk(clk),
		.rstN(rstN),
		.run(run),
		.stall(stall),
		.branchTaken(branchTaken),
		.branchTarget(branchTarget),
		.progWe(progWe),
		.progAddr(progAddr),
		.progData(progData),
		.ifId(ifId)
	);

	decodeStage decode0 (
		.clk(clk),
		.rstN(rstN),
		.ifId(ifId),
		.wb(wb),
		.exMemAlu(exMem.aluOut),
		.brFwdA(brFwdA),
		.brFwdB(brFwdB),
		.flushEx(flushEx),
		.rs(rs),
		.rt(rt),
		.isBranch(isBranch),
		.usesRt(usesRt),
		.branchTaken(branchTaken),
		.branchTarget(branchTarget),
		.idEx(idEx)
	);

	executeStage execute0 (
		.clk(clk),
		.rstN(rstN),
		.idEx(idEx),
		.fwdA(fwdA),
		.fwdB(fwdB),
		.memAluOut(exMem.aluOut),
		.wb(wb),
		.exMem(exMem)
	);

	memoryStage memory0 (
		.clk(clk),
		.rstN(rstN),
		.exMem(exMem),
		.wb(wb)
	);

	hazardUnit hazard0 (
		.rs(rs),
		.rt(rt),
		.isBranch(isBranch),
		.usesRt(usesRt),
		.idEx(idEx),
		.exMem(exMem),
		.stall(stall),
		.flushEx(flushEx),
		.fwdA(fwdA),
		.fwdB(fwdB),
		.brFwdA(brFwdA),
		.brFwdB(brFwdB)
	);

	// Retirement strobe
	assign wbValid = wb.en;
	assign wbDest = wb.dest;
	assign wbData = wb.result;

endmodule

`default_nettype wire

/* sim/cpuChecker.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuChecker (
	input wire clk,
	input wire rstN,
	input wire run,
	input wire wbValid,
	input wire [cpuPkg::regAddrW-1:0] wbDest,
	input wire stall,
	input wire flushEx,
	input wire idExValid,
	input wire [cpuPkg::pcW-1:0] pc
);

	// Failed assertions so far
	int failCount = 0;

	// --------------------------------------------------
	// Pipeline control properties
	// --------------------------------------------------

	// Pipeline comes out of reset idle
	resetIdle: assert property (@(posedge clk) !rstN |=> (!wbValid && !stall && !flushEx))
	else
	begin
		failCount++;
		$error("pipeline not idle after reset");
	end

	// r0 never retires
	noZeroDest: assert property (@(posedge clk) disable iff (!rstN) wbValid |-> (wbDest != '0))
	else
	begin
		failCount++;
		$error("writeback strobe with destination 0");
	end

	// PC frozen over a stall
	pcHeld: assert property (@(posedge clk) disable iff (!rstN) (stall && run) |=> $stable(pc))
	else
	begin
		failCount++;
		$error("program counter moved during a stall");
	end

	// Every stall also drops a bubble into execute
	stallFlush: assert property (@(posedge clk) disable iff (!rstN)
		stall |-> (flushEx ##1 !idExValid))
	else
	begin
		failCount++;
		$error("stall without execute bubble");
	end

endmodule

`default_nettype wire

/* sim/cpuTb.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuTb;

	localparam int clkPeriod = 8;
	localparam int numTests = 8;

	logic clk;
	logic rstN;
	logic run;
	logic progWe;
	logic [cpuPkg::pcW-1:0] progAddr;
	logic [cpuPkg::xlen-1:0] progData;
	logic wbValid;
	logic [cpuPkg::regAddrW-1:0] wbDest;
	logic [cpuPkg::xlen-1:0] wbData;

	// Program image, expected and observed writebacks
	logic [31:0] progQ [$];
	logic [4:0] expDest [$];
	logic [31:0] expData [$];
	logic [4:0] obsDest [$];
	logic [31:0] obsData [$];
	int errCount = 0;
	int testCount = 0;
	int checkedCount = 0;

	cpuTop dut0 (
		.clk(clk),
		.rstN(rstN),
		.run(run),
		.progWe(progWe),
		.progAddr(progAddr),
		.progData(progData),
		.wbValid(wbValid),
		.wbDest(wbDest),
		.wbData(wbData)
	);

	bind cpuTop cpuChecker chk0 (
		.clk(clk),
		.rstN(rstN),
		.run(run),
		.wbValid(wbValid),
		.wbDest(wbDest),
		.stall(stall),
		.flushEx(flushEx),
		.idExValid(idEx.valid),
		.pc(fetch0.pc)
	);

	initial
	begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	// Writeback monitor, sampled mid-cycle
	always @(negedge clk)
	begin
		if (wbValid === 1'b1)
		begin
			obsDest.push_back(wbDest);
			obsData.push_back(wbData);
		end
	end

	// --------------------------------------------------
	// Instruction encoding
	// --------------------------------------------------
	function automatic logic [31:0] encR(input logic [5:0] fn, input logic [4:0] rd,
		input logic [4:0] rs, input logic [4:0] rt);
		return {6'd0, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] encI(input logic [5:0] op, input logic [4:0] rt,
		input logic [4:0] rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// beq r0,r0 back onto itself
	function automatic logic [31:0] haltWord();
		return encI(cpuPkg::opBeq, 5'd0, 5'd0, 16'hffff);
	endfunction

	// --------------------------------------------------
	// Instruction-set reference model
	// --------------------------------------------------
	task automatic predict();
		logic [31:0] regs [32];
		logic [31:0] mem [64];
		logic [31:0] ins;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		logic [31:0] res;
		logic [4:0] wrDest;
		logic wr;
		int pc;
		int target;
		int steps;
		expDest.delete();
		expData.delete();
		foreach (regs[i])
			regs[i] = '0;
		pc = 0;
		steps = 0;
		while (pc < progQ.size() && steps < 500)
		begin
			ins = progQ[pc];
			a = regs[ins[25:21]];
			b = regs[ins[20:16]];
			imm = {{16{ins[15]}}, ins[15:0]};
			wr = 1'b0;
			wrDest = ins[20:16];
			res = '0;
			steps++;
			pc = pc + 1;
			case (ins[31:26])
				cpuPkg::opRtype:
				begin
					wr = 1'b1;
					wrDest = ins[15:11];
					case (ins[5:0])
						cpuPkg::fnAdd: res = a + b;
						cpuPkg::fnSub: res = a - b;
						cpuPkg::fnAnd: res = a & b;
						cpuPkg::fnOr: res = a | b;
						cpuPkg::fnSlt: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						default: wr = 1'b0;
					endcase
				end
				cpuPkg::opAddi:
				begin
					wr = 1'b1;
					res = a + imm;
				end
				cpuPkg::opLw:
				begin
					wr = 1'b1;
					res = mem[(a + imm) % 64];
				end
				cpuPkg::opSw: mem[(a + imm) % 64] = b;
				cpuPkg::opBeq:
				begin
					target = (pc + imm) % 64;
					// Taken branch back to itself ends the program
					if (a == b && target == pc - 1)
						break;
					if (a == b)
						pc = target;
				end
				default: wr = 1'b0;
			endcase
			if (wr && wrDest != 5'd0)
			begin
				regs[wrDest] = res;
				expDest.push_back(wrDest);
				expData.push_back(res);
			end
		end
	endtask

	// --------------------------------------------------
	// Harness tasks
	// --------------------------------------------------
	task automatic loadProgram();
		foreach (progQ[i])
		begin
			@(posedge clk);
			progWe <= 1'b1;
			progAddr <= cpuPkg::pcW'(i);
			progData <= progQ[i];
		end
		@(posedge clk);
		progWe <= 1'b0;
	endtask

	// Bounded wait for a number of strobes
	task automatic waitForWritebacks(input int target);
		int cycles;
		cycles = 0;
		while (obsDest.size() < target && cycles < 150)
		begin
			@(posedge clk);
			cycles++;
		end
	endtask

	task automatic compareResults();
		int n;
		n = (obsDest.size() < expDest.size()) ? obsDest.size() : expDest.size();
		for (int i = 0; i < n; i++)
		begin
			if (obsDest[i] !== expDest[i])
			begin
				$display("[ERROR] wbDest at writeback %0d: expected %h, got %h", i,
					expDest[i], obsDest[i]);
				errCount++;
			end
			if (obsData[i] !== expData[i])
			begin
				$display("[ERROR] wbData at writeback %0d: expected %h, got %h", i,
					expData[i], obsData[i]);
				errCount++;
			end
		end
		if (obsDest.size() < expDest.size())
		begin
			$display("%0d expected writebacks never arrived", expDest.size() - obsDest.size());
			errCount++;
		end
		if (obsDest.size() > expDest.size())
		begin
			$display("%0d writebacks arrived beyond the expected ones",
				obsDest.size() - expDest.size());
			errCount++;
		end
		checkedCount += expDest.size();
	endtask

	// Load, predict, run to the halt, then compare
	task automatic executeProgram();
		loadProgram();
		predict();
		obsDest.delete();
		obsData.delete();
		@(posedge clk);
		run <= 1'b1;
		waitForWritebacks(expDest.size());
		// Room for stray strobes after the last one
		repeat (12) @(posedge clk);
		run <= 1'b0;
		compareResults();
	endtask

	task automatic finishTest(input string name, input int startErrs);
		testCount++;
		$display("%-12s %0d writebacks, %0d errors", name, expDest.size(), errCount - startErrs);
	endtask

	// --------------------------------------------------
	// Directed tests
	// --------------------------------------------------
	task automatic aluChainTest();
		int startErrs;
		startErrs = errCount;
		progQ.delete();
		progQ.push_back(encI(cpuPkg::opAddi, 1, 0, 5));
		progQ.push_back(encI(cpuPkg::opAddi, 2, 0, -3));
		// Operands from writeback and memory stage
		progQ.push_back(encR(cpuPkg::fnAdd, 3, 1, 2));
		progQ.push_back(encR(cpuPkg::fnSub, 4, 3, 1));
		progQ.push_back(encR(cpuPkg::fnAnd, 5, 4, 3));
		progQ.push_back(encR(cpuPkg::fnOr, 6, 5, 2));
		progQ.push_back(encR(cpuPkg::fnSlt, 7, 2, 1));
		progQ.push_back(encR(cpuPkg::fnSlt, 1, 1, 2));
		progQ.push_back(encI(cpuPkg::opAddi, 2, 2, -100));
		progQ.push_back(haltWord());
		executeProgram();
		finishTest("aluChain", startErrs);
	endtask

	task automatic memoryTest();
		int startErrs;
		startErrs = errCount;
		progQ.delete();
		progQ.push_back(encI(cpuPkg::opAddi, 1, 0, 7));
		progQ.push_back(encI(cpuPkg::opAddi, 2, 0, 12));
		progQ.push_back(encI(cpuPkg::opSw, 1, 2, 0));
		progQ.push_back(encI(cpuPkg::opLw, 3, 2, 0));
		// Load-use, one bubble
		progQ.push_back(encR(cpuPkg::fnAdd, 4, 3, 3));
		progQ.push_back(encI(cpuPkg::opSw, 4, 2, 1));
		progQ.push_back(encI(cpuPkg::opLw, 5, 2, 1));
		progQ.push_back(encR(cpuPkg::fnSub, 6, 5, 1));
		progQ.push_back(haltWord());
		executeProgram();
		finishTest("memory", startErrs);
	endtask

	task automatic branchTest();
		int startErrs;
		startErrs = errCount;
		progQ.delete();
		progQ.push_back(encI(cpuPkg::opAddi, 1, 0, 3));
		progQ.push_back(encI(cpuPkg::opAddi, 2, 0, 3));
		// Taken on a fresh ALU result, skips the next word
		progQ.push_back(encI(cpuPkg::opBeq, 2, 1, 1));
		progQ.push_back(encI(cpuPkg::opAddi, 3, 0, 99));
		progQ.push_back(encI(cpuPkg::opAddi, 4, 0, 1));
		// Not taken
		progQ.push_back(encI(cpuPkg::opBeq, 1, 4, 1));
		progQ.push_back(encI(cpuPkg::opAddi, 5, 0, 2));
		progQ.push_back(encI(cpuPkg::opSw, 1, 0, 20));
		progQ.push_back(encI(cpuPkg::opLw, 6, 0, 20));
		// Depends on the load
		progQ.push_back(encI(cpuPkg::opBeq, 2, 6, 1));
		progQ.push_back(encI(cpuPkg::opAddi, 7, 0, 55));
		progQ.push_back(encR(cpuPkg::fnAdd, 7, 6, 5));
		progQ.push_back(haltWord());
		executeProgram();
		finishTest("branch", startErrs);
	endtask

	task automatic regZeroTest();
		int startErrs;
		startErrs = errCount;
		progQ.delete();
		progQ.push_back(encI(cpuPkg::opAddi, 1, 0, 4));
		progQ.push_back(encI(cpuPkg::opAddi, 0, 0, 9));
		progQ.push_back(encR(cpuPkg::fnAdd, 0, 1, 1));
		// r0 must still read zero here
		progQ.push_back(encR(cpuPkg::fnAdd, 2, 0, 1));
		progQ.push_back(encR(cpuPkg::fnOr, 3, 0, 0));
		progQ.push_back(encI(cpuPkg::opAddi, 4, 0, -1));
		progQ.push_back(haltWord());
		executeProgram();
		finishTest("regZero", startErrs);
	endtask

	task automatic resetMidRunTest();
		int startErrs;
		startErrs = errCount;
		progQ.delete();
		progQ.push_back(encI(cpuPkg::opAddi, 1, 0, 1));
		for (int r = 2; r < 8; r++)
			progQ.push_back(encI(cpuPkg::opAddi, r, r - 1, r * 3));
		progQ.push_back(encR(cpuPkg::fnAdd, 1, 7, 6));
		progQ.push_back(encR(cpuPkg::fnSub, 2, 1, 5));
		progQ.push_back(haltWord());
		loadProgram();
		obsDest.delete();
		obsData.delete();
		@(posedge clk);
		run <= 1'b1;
		waitForWritebacks(3);
		if (obsDest.size() < 3)
		begin
			$display("Program never got going before the reset");
			errCount++;
		end
		// Reset in the middle of the program
		@(posedge clk);
		rstN <= 1'b0;
		run <= 1'b0;
		@(posedge clk);
		obsDest.delete();
		obsData.delete();
		repeat (4) @(posedge clk);
		if (obsDest.size() != 0)
		begin
			$display("%0d writebacks seen while reset was held", obsDest.size());
			errCount++;
		end
		rstN <= 1'b1;
		// Reload and expect the full list from address 0
		executeProgram();
		finishTest("resetMidRun", startErrs);
	endtask

	task automatic randomProgramTest(input int idx);
		int startErrs;
		int kind;
		logic [4:0] rd;
		logic [4:0] ra;
		logic [4:0] rb;
		startErrs = errCount;
		progQ.delete();
		// Seed every register the program may read
		for (int r = 1; r < 8; r++)
			progQ.push_back(encI(cpuPkg::opAddi, r, 0, $urandom));
		repeat (20)
		begin
			kind = $urandom_range(0, 5);
			rd = $urandom_range(1, 7);
			ra = $urandom_range(1, 7);
			rb = $urandom_range(1, 7);
			case (kind)
				0: progQ.push_back(encR(cpuPkg::fnAdd, rd, ra, rb));
				1: progQ.push_back(encR(cpuPkg::fnSub, rd, ra, rb));
				2: progQ.push_back(encR(cpuPkg::fnAnd, rd, ra, rb));
				3: progQ.push_back(encR(cpuPkg::fnOr, rd, ra, rb));
				4: progQ.push_back(encR(cpuPkg::fnSlt, rd, ra, rb));
				default: progQ.push_back(encI(cpuPkg::opAddi, rd, ra, $urandom));
			endcase
		end
		progQ.push_back(haltWord());
		executeProgram();
		finishTest($sformatf("random%0d", idx), startErrs);
	endtask

	// --------------------------------------------------
	// Main sequence and watchdog
	// --------------------------------------------------
	initial
	begin
		void'($urandom(54));
		rstN <= 1'b0;
		run <= 1'b0;
		progWe <= 1'b0;
		progAddr <= '0;
		progData <= '0;
		repeat (5) @(posedge clk);
		rstN <= 1'b1;
		aluChainTest();
		memoryTest();
		branchTest();
		regZeroTest();
		resetMidRunTest();
		for (int i = 0; i < 3; i++)
			randomProgramTest(i);
		errCount += dut0.chk0.failCount;
		$display("%0d tests, %0d writebacks checked, %0d errors", testCount, checkedCount,
			errCount);
		if (errCount == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	initial
	begin
		#(numTests * 200 * clkPeriod);
		$display("Watchdog expired before the tests completed");
		$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

/* compile.f */
src/cpuPkg.sv
src/fetchStage.sv
src/decodeStage.sv
src/executeStage.sv
src/memoryStage.sv
src/hazardUnit.sv
src/cpuTop.sv
sim/cpuChecker.sv
sim/cpuTb.sv
